// File: Makefile
# Verilator build and run for the block statistics engine

VERILATOR ?= verilator
TOP       ?= block_stats_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Finished with errors
PASS_MSG  ?= Finished with no errors

SRCS := $(shell grep -v '^+' $(FILELIST))
EXE  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(EXE)
	-./$(EXE) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not complete"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sources.f
src/stat_cfg_pkg.sv
src/stat_types_pkg.sv
src/sample_if.sv
src/sample_buffer.sv
src/block_accumulator.sv
src/variance_unit.sv
src/block_stats.sv
testbench/block_stats_assert.sv
testbench/block_stats_tb.sv

// File: src/block_accumulator.sv
`timescale 1ns/100ps

// Sums block_len values and divides by shifting
// Used for sample sums (mean) and squared differences (variance)
module block_accumulator
	import stat_cfg_pkg::*;
	import stat_types_pkg::*;
#(
	parameter type sum_t = mean_sum_t   // Must hold block_len worst case values
) (
	input  logic clk,
	input  logic rst_n,
	input  logic add,      // Value strobe
	input  sum_t value,
	output logic done,     // Pulse one cycle after the last value of a block
	output sum_t result    // Sum >> block_shift, held until the next block completes
);

	addr_t count;      // Values taken so far in this block
	sum_t  sum;        // Running sum
	sum_t  total;      // Running sum including the present value
	logic  block_end;  // Last value of the block arrives now

	assign total     = sum + value;
	assign block_end = add && (count == addr_t'(block_len - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
			sum   <= '0;
			done  <= 1'b0;
		end else begin
			done <= block_end;
			if (add) begin
				count <= count + 1'b1;            // Wraps to 0 after the last value
				sum   <= block_end ? '0 : total;  // Next block starts clean
			end
		end
	end

	// Result register, only loaded on completion
	always_ff @(posedge clk) begin
		if (block_end) begin
			result <= total >> block_shift;   // Truncating divide by block_len
		end
	end

endmodule

// File: src/block_stats.sv
`timescale 1ns/100ps

// Block mean and variance over blocks of 64 unsigned samples
// Input runs at up to one sample per clock with no back-pressure
module block_stats
	import stat_types_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      in_valid,    // Sample strobe
	input  sample_t   in_data,
	output logic      mean_valid,  // Pulse after the 64th sample of a block
	output mean_t     mean,        // Held until the next mean_valid
	output logic      var_valid,   // Pulse var_latency cycles after mean_valid
	output variance_t variance
);

	sample_if  rd_if ();   // Replay path, buffer to variance unit
	mean_sum_t mean_sum;   // Block sum already shifted down

	// Ping-pong store, replays a block while the next one fills
	sample_buffer u_buf (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.in_data  (in_data),
		.replay   (mean_valid),   // Mean is ready, so replay can start
		.rd       (rd_if.source)
	);

	// Running mean straight off the input stream
	block_accumulator #(
		.sum_t (mean_sum_t)
	) u_mean_acc (
		.clk    (clk),
		.rst_n  (rst_n),
		.add    (in_valid),
		.value  (mean_sum_t'(in_data)),   // Zero extended
		.done   (mean_valid),
		.result (mean_sum)
	);

	assign mean = mean_t'(mean_sum);   // Upper bits always zero after the shift

	// Second pass over the replayed block
	variance_unit u_var (
		.clk       (clk),
		.rst_n     (rst_n),
		.mean      (mean),
		.smp       (rd_if.sink),
		.var_valid (var_valid),
		.variance  (variance)
	);

endmodule

// File: src/sample_buffer.sv
`timescale 1ns/100ps

module sample_buffer
	import stat_cfg_pkg::*;
	import stat_types_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     in_valid,   // Sample strobe, never stalled
	input  sample_t  in_data,
	input  logic     replay,     // Read back the bank just filled
	sample_if.source rd
);

	sample_t mem [2*block_len];  // Two banks, bank select is the address MSB

	addr_t wr_ptr;      // Next write slot in the current bank
	logic  wr_bank;     // Bank being filled
	logic  wr_end;      // Last sample of a block written this cycle
	addr_t rd_ptr;      // Replay read address
	logic  rd_bank;     // Latched at replay start, the writer can flip again before replay ends
	logic  rd_active;   // Issuing read addresses
	logic  rd_end;      // Final read address this cycle

	assign wr_end = in_valid && (wr_ptr == addr_t'(block_len - 1));
	assign rd_end = rd_active && (rd_ptr == addr_t'(block_len - 1));

	// Write side control
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr  <= '0;      // Partial block dropped
			wr_bank <= 1'b0;
		end else if (in_valid) begin
			wr_ptr <= wr_ptr + 1'b1;   // Wraps to 0 at block end
			if (wr_end) begin
				wr_bank <= ~wr_bank;   // Ping-pong on each block boundary
			end
		end
	end

	// Sample storage
	always_ff @(posedge clk) begin
		if (in_valid) begin
			mem[{wr_bank, wr_ptr}] <= in_data;
		end
	end

	// Replay control and framing
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_active <= 1'b0;
			rd_ptr    <= '0;
			rd_bank   <= 1'b0;
			rd.valid  <= 1'b0;
			rd.first  <= 1'b0;
			rd.last   <= 1'b0;
		end else begin
			rd.valid <= rd_active;                       // Aligned with registered read data
			rd.first <= rd_active && (rd_ptr == '0);
			rd.last  <= rd_end;
			if (replay) begin
				rd_active <= 1'b1;
				rd_ptr    <= '0;
				rd_bank   <= ~wr_bank;   // Writer has already moved on
			end else if (rd_active) begin
				rd_ptr <= rd_ptr + 1'b1;
				if (rd_end) begin
					rd_active <= 1'b0;   // 64 addresses issued
				end
			end
		end
	end

	// Registered read port
	always_ff @(posedge clk) begin
		if (rd_active) begin
			rd.data <= mem[{rd_bank, rd_ptr}];
		end
	end

endmodule

// File: src/sample_if.sv
`timescale 1ns/100ps

// Replayed sample stream from the ping-pong buffer
// One sample per valid cycle, a block is never interrupted
interface sample_if
	import stat_types_pkg::*;
();

	logic    valid;   // Sample present this cycle
	sample_t data;
	logic    first;   // Sample 0 of a block
	logic    last;    // Sample 63 of a block

	modport source (
		output valid,
		output data,
		output first,
		output last
	);

	modport sink (
		input valid,
		input data,
		input first,
		input last
	);

endinterface

// File: src/stat_cfg_pkg.sv
package stat_cfg_pkg;

	// Sample format
	localparam int sample_width = 8;    // Bits per unsigned input sample

	// Block framing, power of two only
	localparam int block_len   = 64;    // Samples per block
	localparam int block_shift = 6;     // log2(block_len), divide is a right shift

	// Output pulse spacing, counted from the mean_valid cycle:
	//   1  replay start registers the read address counter
	//   1  registered read of sample 0
	//   63 remaining samples stream out
	//   1  difference stage
	//   1  square stage
	//   1  accumulator loads the result
	localparam int var_latency = 68;    // mean_valid to var_valid, in cycles

	// Fill and replay both take block_len cycles at best,
	// so each replay starts well before the next mean arrives,
	// but the last differences of a block can trail that mean,
	// so the variance unit keeps its own copy of the mean per block

endpackage

// File: src/stat_types_pkg.sv
package stat_types_pkg;

	import stat_cfg_pkg::*;

	// Raw input
	typedef logic [sample_width-1:0] sample_t;                // Unsigned sample

	// Variance datapath
	typedef logic signed [sample_width:0] diff_t;             // Sample minus mean, -255..255
	typedef logic [2*sample_width-1:0] square_t;              // Up to 255*255

	// Block sums, sized so 64 worst case values never overflow
	typedef logic [sample_width+block_shift-1:0] mean_sum_t;  // 64 * 255
	typedef logic [2*sample_width+block_shift-1:0] var_sum_t; // 64 * 65025

	// Reported results after the shift
	typedef logic [sample_width-1:0] mean_t;
	typedef logic [2*sample_width-1:0] variance_t;

	// Position inside a block, wraps naturally at block_len
	typedef logic [block_shift-1:0] addr_t;

endpackage

// File: src/variance_unit.sv
`timescale 1ns/100ps

// Population variance of one replayed block about its truncated mean
module variance_unit
	import stat_types_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  mean_t     mean,       // Mean of the block, valid when its replay starts
	sample_if.sink    smp,
	output logic      var_valid,
	output variance_t variance
);

	logic     in_block;    // Between first and last of a framed block
	logic     take;        // Sample enters the pipeline
	mean_t    blk_mean;    // Mean latched with sample 0 of the replay
	logic     diff_valid;
	diff_t    diff;        // Stage 1 result
	logic     sq_valid;
	square_t  sq;          // Stage 2 result
	var_sum_t var_sum;     // Accumulator output, sum of squares >> 6

	// Only framed samples count, a stray sample outside a block is ignored
	assign take = smp.valid && (smp.first || in_block);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			in_block <= 1'b0;
		end else if (take && smp.last) begin
			in_block <= 1'b0;
		end else if (take && smp.first) begin
			in_block <= 1'b1;
		end
	end

	// Pipeline valids
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			diff_valid <= 1'b0;
			sq_valid   <= 1'b0;
		end else begin
			diff_valid <= take;
			sq_valid   <= diff_valid;
		end
	end

	// Stage 1 difference, stage 2 square
	always_ff @(posedge clk) begin
		if (take && smp.first) begin
			blk_mean <= mean;   // Next block's mean can land before this replay ends
		end
		if (take) begin
			// 9 bits, no overflow
			diff <= diff_t'(smp.data) - diff_t'(smp.first ? mean : blk_mean);
		end
		if (diff_valid) begin
			// Sign extended operands, low 16 bits hold the exact square
			sq <= square_t'(diff) * square_t'(diff);
		end
	end

	// Sum of squares over the block
	block_accumulator #(
		.sum_t (var_sum_t)
	) u_var_acc (
		.clk    (clk),
		.rst_n  (rst_n),
		.add    (sq_valid),
		.value  (var_sum_t'(sq)),
		.done   (var_valid),
		.result (var_sum)
	);

	assign variance = variance_t'(var_sum);   // Max 65025 after the shift

endmodule

// File: testbench/block_stats_assert.sv
`timescale 1ns/100ps

// Output pulse timing checks, bound into block_stats
module block_stats_assert
	import stat_cfg_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic mean_valid,
	input logic var_valid
);

	// Variance lands a fixed distance after its mean
	a_var_follows_mean: assert property (@(posedge clk) disable iff (!rst_n)
		mean_valid |-> ##var_latency var_valid)
		else $error("var_valid missing %0d cycles after mean_valid", var_latency);

	// No variance without a mean before it
	a_var_has_mean: assert property (@(posedge clk) disable iff (!rst_n)
		var_valid |-> $past(mean_valid, var_latency))
		else $error("var_valid without a matching mean_valid");

	a_mean_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		mean_valid |=> !mean_valid)
		else $error("mean_valid held longer than one cycle");

	a_var_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		var_valid |=> !var_valid)
		else $error("var_valid held longer than one cycle");

	a_quiet_in_reset: assert property (@(posedge clk)
		!rst_n |-> (!mean_valid && !var_valid))
		else $error("result pulse while in reset");

endmodule

bind block_stats block_stats_assert u_assert (
	.clk        (clk),
	.rst_n      (rst_n),
	.mean_valid (mean_valid),
	.var_valid  (var_valid)
);

// File: testbench/block_stats_tb.sv
`timescale 1ns/100ps

module block_stats_tb
	import stat_cfg_pkg::*;
	import stat_types_pkg::*;
();

	localparam int reset_cycles = 16;
	localparam int max_gap      = 3;    // Idle cycles allowed before a sample
	localparam int num_blocks   = 14;   // Full blocks sent over all tests
	// Worst case fill with gaps, plus result latency per block, plus resets and idles
	localparam int timeout_cycles = num_blocks * block_len * (max_gap + 1)
		+ num_blocks * (var_latency + 8) + 600;

	logic      clk;
	logic      rst_n;
	logic      in_valid;
	sample_t   in_data;
	logic      mean_valid;
	mean_t     mean;
	logic      var_valid;
	variance_t variance;

	sample_t   blk [block_len];   // Block being built for the next send
	mean_t     mean_q [$];        // Expected results in block order
	variance_t var_q [$];
	int        mean_idx = 0;
	int        var_idx = 0;
	int        cycles = 0;
	integer    seed;

	block_stats dut_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_data    (in_data),
		.mean_valid (mean_valid),
		.mean       (mean),
		.var_valid  (var_valid),
		.variance   (variance)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;   // 40 ns period

	// Run limit
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= timeout_cycles) begin
			$display("Timeout after %0d cycles, results never arrived", cycles);
			$display("Finished with errors");
			$fatal(1, "simulation timed out");
		end
	end

	task automatic compare_mean(input mean_t got, input mean_t exp, input string what);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s mean is %0d, expected %0d", $time, what, got, exp);
			$display("Finished with errors");
			$fatal(1, "wrong mean");
		end
	endtask

	task automatic compare_variance(input variance_t got, input variance_t exp,
		input string what);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s variance is %0d, expected %0d",
				$time, what, got, exp);
			$display("Finished with errors");
			$fatal(1, "wrong variance");
		end
	endtask

	// Outputs are registered, so the falling edge sees them settled
	always @(negedge clk) begin
		if (mean_valid) begin
			if (mean_q.size() == 0) begin
				$display("mean_valid pulsed at %0t with no completed block", $time);
				$display("Finished with errors");
				$fatal(1, "unexpected mean pulse");
			end else begin
				compare_mean(mean, mean_q.pop_front(), $sformatf("block %0d", mean_idx));
				mean_idx++;
			end
		end
	end

	always @(negedge clk) begin
		if (var_valid) begin
			if (var_q.size() == 0) begin
				$display("var_valid pulsed at %0t with no completed block", $time);
				$display("Finished with errors");
				$fatal(1, "unexpected variance pulse");
			end else begin
				compare_variance(variance, var_q.pop_front(), $sformatf("block %0d", var_idx));
				var_idx++;
			end
		end
	end

	// Reference model, truncating divide by 64
	function automatic int model_mean();
		int sum;
		int i;
		sum = 0;
		for (i = 0; i < block_len; i++) sum += int'(blk[i]);
		return sum >> block_shift;
	endfunction

	function automatic int model_variance(input int m);
		int sq_sum;
		int d;
		int i;
		sq_sum = 0;
		for (i = 0; i < block_len; i++) begin
			d = int'(blk[i]) - m;   // About the truncated mean
			sq_sum += d * d;
		end
		return sq_sum >> block_shift;
	endfunction

	task automatic fill_const(input sample_t v);
		int i;
		for (i = 0; i < block_len; i++) blk[i] = v;
	endtask

	task automatic fill_ramp();
		int i;
		for (i = 0; i < block_len; i++) blk[i] = sample_t'(i);
	endtask

	task automatic fill_alternate();
		int i;
		for (i = 0; i < block_len; i++) blk[i] = (i % 2 == 0) ? 8'd0 : 8'd255;
	endtask

	task automatic fill_random();
		int i;
		for (i = 0; i < block_len; i++) blk[i] = sample_t'($random(seed));
	endtask

	task automatic expect_values(input mean_t m, input variance_t v);
		mean_q.push_back(m);
		var_q.push_back(v);
	endtask

	task automatic expect_model();
		int m;
		m = model_mean();
		expect_values(mean_t'(m), variance_t'(model_variance(m)));
	endtask

	// Drive the first n samples of blk, random idle cycles up to gap_limit before each
	task automatic drive_samples(input int n, input int gap_limit);
		int gap;
		int i;
		for (i = 0; i < n; i++) begin
			if (gap_limit > 0) begin
				gap = {$random(seed)} % (gap_limit + 1);
				in_valid = 1'b0;
				repeat (gap) @(negedge clk);
			end
			in_valid = 1'b1;
			in_data  = blk[i];
			@(negedge clk);
		end
		in_valid = 1'b0;   // Next block may start in this same step
	endtask

	task automatic wait_results();
		while (mean_q.size() != 0 || var_q.size() != 0) @(negedge clk);
		repeat (4) @(negedge clk);
	endtask

	task automatic apply_reset();
		rst_n    = 1'b0;
		in_valid = 1'b0;
		repeat (reset_cycles) @(negedge clk);
		rst_n = 1'b1;
	endtask

	task automatic test_constant();
		fill_const(8'd173);
		expect_values(8'd173, 16'd0);   // No spread
		drive_samples(block_len, 0);
		wait_results();
	endtask

	task automatic test_ramp();
		fill_ramp();
		expect_values(8'd31, variance_t'(model_variance(31)));   // 2016 / 64
		drive_samples(block_len, 0);
		wait_results();
	endtask

	task automatic test_alternate();
		fill_alternate();
		expect_values(8'd127, 16'd16256);   // Diffs of -127 and 128
		drive_samples(block_len, 0);
		wait_results();
	endtask

	// Four blocks with no idle cycle between them
	task automatic test_back_to_back();
		int b;
		for (b = 0; b < 4; b++) begin
			fill_random();
			expect_model();
			drive_samples(block_len, 0);
		end
		wait_results();
	endtask

	// Same blocks twice, full rate then gapped
	task automatic test_gaps();
		integer blk_seed [3];   // Seed at the start of each block
		int b;
		for (b = 0; b < 3; b++) begin
			blk_seed[b] = seed;
			fill_random();
			expect_model();
			drive_samples(block_len, 0);
		end
		wait_results();
		for (b = 0; b < 3; b++) begin
			seed = blk_seed[b];   // Same data, the gaps draw from the seed too
			fill_random();
			expect_model();
			drive_samples(block_len, max_gap);
		end
		wait_results();
	endtask

	task automatic test_reset_midblock();
		fill_random();
		drive_samples(29, 1);   // Partial block, nothing expected
		apply_reset();
		repeat (3 * block_len) @(negedge clk);   // Monitors flag any stray pulse
		fill_random();
		expect_model();
		drive_samples(block_len, 1);
		wait_results();
	endtask

	initial begin
		seed     = 32'ha187;
		rst_n    = 1'b0;
		in_valid = 1'b0;
		in_data  = '0;
		repeat (reset_cycles) @(negedge clk);
		rst_n = 1'b1;
		repeat (2) @(negedge clk);

		test_constant();
		test_ramp();
		test_alternate();
		test_back_to_back();
		test_gaps();
		test_reset_midblock();

		$display("Finished with no errors");
		$finish;
	end

endmodule
